/* Makefile */
# Verilator lint and simulation of the cartridge loader testbench

VERILATOR  ?= verilator
FLIST      := flist.f
TOP        := tb_nes_loader
OBJ_DIR    := obj_dir
LINT_FLAGS := --lint-only --timing
SIM_FLAGS  := --binary --timing -j 0
PASS_MSG   := Result: PASSED

.PHONY: all lint build sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FLIST)

build:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FLIST)

# The run passes only if the pass message shows up in the output
sim: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qF "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

/* flist.f */
+incdir+.
nes_loader_pkg.sv
ines_header_if.sv
ines_header_decode.sv
game_loader_ctrl.sv
loader_write_stage.sv
nes_loader_top.sv
tb_nes_loader.sv

/* game_loader_ctrl.sv */
//////////////////////////////
// Loader FSM for iNES images
// Captures the header then streams PRG and CHR bytes
// with their cartridge addresses into the write stage
//////////////////////////////

`default_nettype none

`include "nes_loader_defs.svh"

module game_loader_ctrl (
	input  logic                      clk,
	input  logic                      reset_nes,
	input  logic                      downloading,
	input  nes_loader_pkg::byte_t     indata,
	input  logic                      indata_clk,
	ines_header_if.ctrl               hdr_bus,
	output nes_loader_pkg::mem_addr_t loader_stage_addr,
	output nes_loader_pkg::byte_t     loader_stage_data,
	output logic                      loader_stage_write,
	output logic                      busy,
	output logic                      done,
	output logic                      error
);

	localparam int CTR_W = $clog2(`INES_HDR_LEN);

	nes_loader_pkg::loader_state_t state;
	logic [CTR_W-1:0]              hdr_ctr;
	nes_loader_pkg::mem_addr_t     addr;
	nes_loader_pkg::byte_count_t   bytes_left;
	logic                          in_header;
	logic                          in_payload;
	logic                          last_hdr_byte;

	assign in_header  = (state == nes_loader_pkg::S_LOADHEADER);
	assign in_payload = (state == nes_loader_pkg::S_LOADPRG) ||
		(state == nes_loader_pkg::S_LOADCHR);

	// Byte accepted this cycle
	assign loader_stage_write = indata_clk && downloading &&
		(in_header || (in_payload && (bytes_left != '0)));

	assign loader_stage_addr = addr;
	assign loader_stage_data = indata;
	assign last_hdr_byte     = (hdr_ctr == CTR_W'(`INES_HDR_LEN - 1));

	// Header capture
	always_ff @(posedge clk) begin
		if (loader_stage_write && in_header) begin
			hdr_bus.hdr[hdr_ctr] <= indata;
		end
	end

	//////////////////////////////
	// State machine
	//////////////////////////////
	always_ff @(posedge clk) begin
		if (reset_nes) begin
			state      <= nes_loader_pkg::S_LOADHEADER;
			hdr_ctr    <= '0;
			addr       <= '0;
			bytes_left <= '0;
			busy       <= 1'b0;
			done       <= 1'b0;
			error      <= 1'b0;
		end else begin
			case (state)
				nes_loader_pkg::S_LOADHEADER: begin
					if (loader_stage_write) begin
						hdr_ctr <= hdr_ctr + 1'b1;
						addr    <= addr + 1'b1;
						// Magic, trainer bit and page counts are already in by byte 16
						if (last_hdr_byte) begin
							busy <= 1'b1;
							if (hdr_bus.hdr_ok) begin
								state      <= nes_loader_pkg::S_LOADPRG;
								addr       <= '0;
								bytes_left <= hdr_bus.prg_bytes;
							end else begin
								state <= nes_loader_pkg::S_ERROR;
							end
						end
					end
				end

				nes_loader_pkg::S_LOADPRG, nes_loader_pkg::S_LOADCHR: begin
					if (bytes_left != '0) begin
						if (loader_stage_write) begin
							bytes_left <= bytes_left - 1'b1;
							addr       <= addr + 1'b1;
						end
					end else if (state == nes_loader_pkg::S_LOADPRG) begin
						state      <= nes_loader_pkg::S_LOADCHR;
						addr       <= `CHR_BASE_ADDR;
						bytes_left <= hdr_bus.chr_bytes;  // Zero for CHR RAM carts
					end else begin
						state <= nes_loader_pkg::S_DONE;
						done  <= 1'b1;
						busy  <= 1'b0;
					end
				end

				nes_loader_pkg::S_ERROR: begin
					state <= nes_loader_pkg::S_DONE;
					done  <= 1'b1;
					error <= 1'b1;
					busy  <= 1'b0;
				end

				// Terminal until reset
				nes_loader_pkg::S_DONE: begin
					done <= 1'b1;
					busy <= 1'b0;
				end

				default: begin
					state <= nes_loader_pkg::S_ERROR;
				end
			endcase
		end
	end

endmodule

`default_nettype wire

/* ines_header_decode.sv */
//////////////////////////////
// Combinational iNES header decode
// Gives validity, PRG/CHR byte counts and the mapper flags word
//////////////////////////////

`default_nettype none

`include "nes_loader_defs.svh"

module ines_header_decode (
	ines_header_if.decode hdr_bus,
	input  logic          invert_mirroring
);

	nes_loader_pkg::byte_t      prg_pages;
	nes_loader_pkg::byte_t      chr_pages;
	nes_loader_pkg::size_code_t prg_size;
	nes_loader_pkg::size_code_t chr_size;
	nes_loader_pkg::byte_t      mapper;
	logic                       magic_ok;
	logic                       has_trainer;
	logic                       is_nes20;
	logic                       is_dirty;

	// Page count to the smallest power-of-two code that holds it
	function automatic nes_loader_pkg::size_code_t size_code(input nes_loader_pkg::byte_t pages);
		if (pages <= 8'd1)
			return 3'd0;
		else if (pages <= 8'd2)
			return 3'd1;
		else if (pages <= 8'd4)
			return 3'd2;
		else if (pages <= 8'd8)
			return 3'd3;
		else if (pages <= 8'd16)
			return 3'd4;
		else if (pages <= 8'd32)
			return 3'd5;
		else if (pages <= 8'd64)
			return 3'd6;
		else
			return 3'd7;
	endfunction

	assign prg_pages = hdr_bus.hdr[4];
	assign chr_pages = hdr_bus.hdr[5];

	//////////////////////////////
	// Validity
	//////////////////////////////
	assign magic_ok = (hdr_bus.hdr[0] == `INES_MAGIC0) && (hdr_bus.hdr[1] == `INES_MAGIC1) &&
		(hdr_bus.hdr[2] == `INES_MAGIC2) && (hdr_bus.hdr[3] == `INES_MAGIC3);
	assign has_trainer = hdr_bus.hdr[6][2];
	assign hdr_bus.hdr_ok = magic_ok && !has_trainer;

	// Sizes
	assign hdr_bus.prg_bytes = nes_loader_pkg::byte_count_t'(prg_pages) << `PRG_PAGE_SHIFT;
	assign hdr_bus.chr_bytes = nes_loader_pkg::byte_count_t'(chr_pages) << `CHR_PAGE_SHIFT;
	assign prg_size = size_code(prg_pages);
	assign chr_size = size_code(chr_pages);

	//////////////////////////////
	// Header flavour
	//////////////////////////////
	assign is_nes20 = (hdr_bus.hdr[7][3:2] == 2'b10);

	// Old dumps often carry junk here, so the upper mapper nibble can't be trusted.
	// Bit 0 of byte 9 is the TV system and is legal in 1.0 headers
	assign is_dirty = !is_nes20 && ((hdr_bus.hdr[9][7:1] != 7'd0) ||
		(|hdr_bus.hdr[10]) || (|hdr_bus.hdr[11]) || (|hdr_bus.hdr[12]) ||
		(|hdr_bus.hdr[13]) || (|hdr_bus.hdr[14]) || (|hdr_bus.hdr[15]));

	assign mapper = {is_dirty ? 4'h0 : hdr_bus.hdr[7][7:4], hdr_bus.hdr[6][7:4]};

	// Flags word
	always_comb begin
		hdr_bus.flags               = '0;
		hdr_bus.flags.piano         = is_nes20 && (hdr_bus.hdr[15][5:0] == 6'h19);
		hdr_bus.flags.prg_ram_shift = is_nes20 ? hdr_bus.hdr[10][3:0] : 4'h0;
		hdr_bus.flags.has_saves     = hdr_bus.hdr[6][1];  // Battery bit
		hdr_bus.flags.submapper     = is_nes20 ? hdr_bus.hdr[8] : 8'h00;
		hdr_bus.flags.four_screen   = hdr_bus.hdr[6][3];
		hdr_bus.flags.has_chr_ram   = (chr_pages == 8'd0);
		hdr_bus.flags.mirroring     = hdr_bus.hdr[6][0] ^ invert_mirroring;
		hdr_bus.flags.chr_size      = chr_size;
		hdr_bus.flags.prg_size      = prg_size;
		hdr_bus.flags.mapper        = mapper;
	end

endmodule

`default_nettype wire

/* ines_header_if.sv */
//////////////////////////////
// Header bytes out to the decoder and decoded results back
// ctrl side captures, decode side is pure logic
//////////////////////////////

`default_nettype none

interface ines_header_if;

	nes_loader_pkg::ines_hdr_t     hdr;
	logic                          hdr_ok;     // Magic matches and no trainer
	nes_loader_pkg::byte_count_t   prg_bytes;
	nes_loader_pkg::byte_count_t   chr_bytes;
	nes_loader_pkg::mapper_flags_t flags;

	modport ctrl (
		output hdr,
		input  hdr_ok, prg_bytes, chr_bytes
	);

	modport decode (
		input  hdr,
		output hdr_ok, prg_bytes, chr_bytes, flags
	);

endinterface

`default_nettype wire

/* loader_testdata.txt */
# name  header bytes 0-3 4-7 8-11 12-15 (hex)  invert_mirroring  expected_error  expected_flags
# Bytes go out in order from the left, PRG/CHR payload is generated by the testbench
basic_nrom         4E45531A 01010000 00000000 00000000 0 0 00000000
mirror_vertical    4E45531A 01011100 00000000 00000000 0 0 00004001
mirror_inverted    4E45531A 01011100 00000000 00000000 1 0 00000001
clean_10_battery   4E45531A 02024210 00010000 00000000 0 0 02000914
dirty_10_junk      4E45531A 010131A0 00004469 736B4475 0 0 00004003
dirty_10_byte9     4E45531A 01001020 00020000 00000000 1 0 0000C001
nes20_piano        4E45531A 01014318 35000700 00000019 1 0 5E6A0014
nes20_four_screen  4E45531A 01000808 00117000 00000000 0 0 00018000
bad_magic_last     4E45531B 01010000 00000000 00000000 0 1 00000000
bad_magic_first    4D45531A 01010000 00000000 00000000 0 1 00000000
trainer            4E45531A 01010500 00000000 00000000 0 1 00004000
trainer_big_sizes  4E45531A 40810400 00000000 00000000 0 1 00003E00

/* loader_write_stage.sv */
//////////////////////////////
// Commits loader bytes to cartridge memory
// One write per memory slot, host held off with ioctl_wait
//////////////////////////////

`default_nettype none

`include "nes_loader_defs.svh"

module loader_write_stage (
	input  logic                      clk,
	input  logic                      reset_nes,
	input  nes_loader_pkg::mem_addr_t loader_stage_addr,
	input  nes_loader_pkg::byte_t     loader_stage_data,
	input  logic                      loader_stage_write,
	output nes_loader_pkg::mem_addr_t mem_addr,
	output nes_loader_pkg::byte_t     mem_data,
	output logic                      mem_write,
	output logic                      ioctl_wait
);

	localparam int SLOT_W = $clog2(`MEM_SLOT_DIV);

	logic [SLOT_W-1:0] slot_cnt;
	logic              slot;
	logic              pending;  // Byte staged but not yet written

	assign slot = (slot_cnt == SLOT_W'(`MEM_SLOT_DIV - 1));

	// Slot divider
	always_ff @(posedge clk) begin
		if (reset_nes)
			slot_cnt <= '0;
		else if (slot)
			slot_cnt <= '0;
		else
			slot_cnt <= slot_cnt + 1'b1;
	end

	// Staging register, held until the slot commits it
	always_ff @(posedge clk) begin
		if (loader_stage_write) begin
			mem_addr <= loader_stage_addr;
			mem_data <= loader_stage_data;
		end
	end

	//////////////////////////////
	// Commit and host wait
	//////////////////////////////
	always_ff @(posedge clk) begin
		if (reset_nes) begin
			pending    <= 1'b0;
			mem_write  <= 1'b0;
			ioctl_wait <= 1'b0;
		end else begin
			mem_write <= 1'b0;
			if (slot) begin
				mem_write <= pending;
				if (pending)
					pending <= 1'b0;
				else
					ioctl_wait <= 1'b0;  // Released one slot after the write
			end
			// New byte wins over a release in the same cycle
			if (loader_stage_write) begin
				pending    <= 1'b1;
				ioctl_wait <= 1'b1;
			end
		end
	end

endmodule

`default_nettype wire

/* nes_loader_defs.svh */
//////////////////////////////
// Cartridge loader constants
// Include wherever sizes, addresses or magic bytes are needed
//////////////////////////////

`ifndef NES_LOADER_DEFS_SVH
`define NES_LOADER_DEFS_SVH

// iNES header length in bytes
`define INES_HDR_LEN    16

// Page sizes as shift amounts
`define PRG_PAGE_SHIFT  14  // 16 KB PRG pages
`define CHR_PAGE_SHIFT  13  // 8 KB CHR pages

// Cartridge memory
`define LOADER_ADDR_W   22
`define CHR_BASE_ADDR   22'h30_0000  // Top quarter of the space

// "NES" followed by end-of-file
`define INES_MAGIC0     8'h4E
`define INES_MAGIC1     8'h45
`define INES_MAGIC2     8'h53
`define INES_MAGIC3     8'h1A

// One memory slot every this many clocks
`define MEM_SLOT_DIV    4

`endif

/* nes_loader_pkg.sv */
//////////////////////////////
// Types shared by the cartridge loader blocks
// Referenced through scoped names only
//////////////////////////////

`default_nettype none

`include "nes_loader_defs.svh"

package nes_loader_pkg;

	typedef logic [7:0] byte_t;
	typedef logic [`LOADER_ADDR_W-1:0] mem_addr_t;
	typedef logic [`LOADER_ADDR_W-1:0] byte_count_t;  // Bytes still to come

	// Raw header as captured from the stream
	typedef byte_t ines_hdr_t [`INES_HDR_LEN];

	// Power-of-two size code, 0 is the smallest size
	typedef logic [2:0] size_code_t;

	typedef enum logic [2:0] {
		S_LOADHEADER,
		S_LOADPRG,
		S_LOADCHR,
		S_ERROR,
		S_DONE
	} loader_state_t;

	//////////////////////////////
	// Mapper flags word handed to the console core
	//////////////////////////////
	typedef struct packed {
		logic       spare;
		logic       piano;          // Miracle piano cart
		logic [3:0] prg_ram_shift;  // PRG RAM is 64 << shift
		logic       has_saves;
		byte_t      submapper;      // Whole byte 8 of a NES 2.0 header
		logic       four_screen;
		logic       has_chr_ram;
		logic       mirroring;
		size_code_t chr_size;
		size_code_t prg_size;
		byte_t      mapper;
	} mapper_flags_t;

endpackage

`default_nettype wire

/* nes_loader_top.sv */
//////////////////////////////
// Cartridge loader top level
// Host byte stream in, cartridge memory writes and mapper flags out
//////////////////////////////

`default_nettype none

`include "nes_loader_defs.svh"

module nes_loader_top (
	input  logic                      clk,
	input  logic                      reset_nes,
	input  logic                      downloading,
	input  logic [7:0]                indata,
	input  logic                      indata_clk,
	input  logic                      invert_mirroring,
	output logic                      ioctl_wait,
	output logic [`LOADER_ADDR_W-1:0] mem_addr,
	output logic [7:0]                mem_data,
	output logic                      mem_write,
	output logic [31:0]               mapper_flags,
	output logic                      busy,
	output logic                      done,
	output logic                      error
);

	nes_loader_pkg::mem_addr_t stage_addr;
	nes_loader_pkg::byte_t     stage_data;
	logic                      stage_write;

	ines_header_if hdr_if ();

	ines_header_decode u_decode (
		.hdr_bus          (hdr_if.decode),
		.invert_mirroring (invert_mirroring)
	);

	game_loader_ctrl u_ctrl (
		.clk                (clk),
		.reset_nes          (reset_nes),
		.downloading        (downloading),
		.indata             (indata),
		.indata_clk         (indata_clk),
		.hdr_bus            (hdr_if.ctrl),
		.loader_stage_addr  (stage_addr),
		.loader_stage_data  (stage_data),
		.loader_stage_write (stage_write),
		.busy               (busy),
		.done               (done),
		.error              (error)
	);

	loader_write_stage u_stage (
		.clk                (clk),
		.reset_nes          (reset_nes),
		.loader_stage_addr  (stage_addr),
		.loader_stage_data  (stage_data),
		.loader_stage_write (stage_write),
		.mem_addr           (mem_addr),
		.mem_data           (mem_data),
		.mem_write          (mem_write),
		.ioctl_wait         (ioctl_wait)
	);

	// Decoded flags are steady once the header is in
	assign mapper_flags = hdr_if.flags;

endmodule

`default_nettype wire

/* tb_nes_loader.sv */
//////////////////////////////
// Testbench for the cartridge loader
// Streams one iNES image per test data line, checks memory and flags
//////////////////////////////

`default_nettype none

`include "nes_loader_defs.svh"

module tb_nes_loader;

	timeunit 1ns;
	timeprecision 1ps;

	localparam int CLK_PERIOD  = 10;
	localparam int TRAIL_BYTES = 4;  // Sent after done, must be dropped

	typedef logic [`LOADER_ADDR_W-1:0] addr_t;

	logic        clk;
	logic        reset_nes;
	logic        downloading;
	logic [7:0]  indata;
	logic        indata_clk;
	logic        invert_mirroring;
	logic        ioctl_wait;
	addr_t       mem_addr;
	logic [7:0]  mem_data;
	logic        mem_write;
	logic [31:0] mapper_flags;
	logic        busy;
	logic        done;
	logic        error;

	integer seed = 32'hbcea_8250;
	longint watch_ns = 0;

	// Test table
	string        t_name[$];
	logic [127:0] t_hdr[$];
	logic         t_inv[$];
	logic         t_err[$];
	logic [31:0]  t_flags[$];

	// Cartridge memory model
	logic [7:0]  mem_model [addr_t];
	addr_t       hdr_log_addr[$];
	logic [7:0]  hdr_log_data[$];
	int          write_count;
	int          chr_writes;

	nes_loader_top dut (
		.clk              (clk),
		.reset_nes        (reset_nes),
		.downloading      (downloading),
		.indata           (indata),
		.indata_clk       (indata_clk),
		.invert_mirroring (invert_mirroring),
		.ioctl_wait       (ioctl_wait),
		.mem_addr         (mem_addr),
		.mem_data         (mem_data),
		.mem_write        (mem_write),
		.mapper_flags     (mapper_flags),
		.busy             (busy),
		.done             (done),
		.error            (error)
	);

	initial begin
		clk = 1'b0;
		forever #(CLK_PERIOD / 2) clk = ~clk;
	end

	// Mid-cycle sampling of the one-cycle write pulse
	always @(negedge clk) begin
		if (mem_write) begin
			if (hdr_log_addr.size() < `INES_HDR_LEN) begin
				hdr_log_addr.push_back(mem_addr);
				hdr_log_data.push_back(mem_data);
			end
			if (mem_addr >= `CHR_BASE_ADDR)
				chr_writes++;
			mem_model[mem_addr] = mem_data;
			write_count++;
		end
	end

	initial begin
		wait (watch_ns != 0);
		#(watch_ns);
		fail_run($sformatf("timeout: loader did not finish within %0d ns", watch_ns));
	end

	//////////////////////////////
	// Helpers
	//////////////////////////////
	task automatic fail_run(input string msg);
		$display("%s", msg);
		$display("Result: FAILED");
		$fatal(1, "run stopped at first error");
	endtask

	task automatic check_value(input string what, input logic [31:0] expected,
		input logic [31:0] actual);
		if (actual !== expected) begin
			fail_run($sformatf("mismatch %s: expected %h actual %h", what, expected, actual));
		end
	endtask

	function automatic logic [7:0] hdr_byte(input logic [127:0] h, input int i);
		return 8'(h >> (8 * (`INES_HDR_LEN - 1 - i)));  // Byte 0 sits at the top
	endfunction

	function automatic int prg_length(input logic [127:0] h);
		return int'(hdr_byte(h, 4)) << `PRG_PAGE_SHIFT;
	endfunction

	function automatic int chr_length(input logic [127:0] h);
		return int'(hdr_byte(h, 5)) << `CHR_PAGE_SHIFT;
	endfunction

	task automatic load_tests();
		int          fd;
		int          n;
		string       line;
		string       name;
		logic [31:0] w0, w1, w2, w3, inv, err, flags;
		fd = $fopen("loader_testdata.txt", "r");
		if (fd == 0)
			fail_run("cannot open loader_testdata.txt");
		while (!$feof(fd)) begin
			line = "";
			n = $fgets(line, fd);
			if (n > 0 && line.getc(0) != "#") begin
				n = $sscanf(line, "%s %h %h %h %h %h %h %h", name, w0, w1, w2, w3, inv, err, flags);
				if (n == 8) begin
					t_name.push_back(name);
					t_hdr.push_back({w0, w1, w2, w3});
					t_inv.push_back(inv[0]);
					t_err.push_back(err[0]);
					t_flags.push_back(flags);
				end
			end
		end
		$fclose(fd);
		if (t_name.size() == 0)
			fail_run("test data file holds no test lines");
	endtask

	// Host sends one byte only while wait is low
	task automatic send_byte(input logic [7:0] b);
		int idle;
		idle = int'($unsigned($random(seed)) % 3);
		repeat (idle) @(posedge clk);
		while (ioctl_wait) @(posedge clk);
		indata     <= b;
		indata_clk <= 1'b1;
		@(posedge clk);
		indata_clk <= 1'b0;
		@(posedge clk);  // Wait level now covers this byte
	endtask

	//////////////////////////////
	// One image
	//////////////////////////////
	task automatic run_test(input int idx);
		string        name;
		logic [127:0] hdr;
		int           prg_len;
		int           chr_len;
		int           total;
		logic [7:0]   payload[$];
		addr_t        a;
		name    = t_name[idx];
		hdr     = t_hdr[idx];
		prg_len = t_err[idx] ? 0 : prg_length(hdr);
		chr_len = t_err[idx] ? 0 : chr_length(hdr);
		total   = `INES_HDR_LEN + prg_len + chr_len;
		@(posedge clk);
		reset_nes        <= 1'b1;
		downloading      <= 1'b0;
		indata_clk       <= 1'b0;
		invert_mirroring <= t_inv[idx];
		repeat (16) @(posedge clk);
		check_value({name, " idle after reset"}, 32'h0,
			32'({busy, done, error, mem_write, ioctl_wait}));
		reset_nes   <= 1'b0;
		downloading <= 1'b1;
		mem_model.delete();
		hdr_log_addr.delete();
		hdr_log_data.delete();
		write_count = 0;
		chr_writes  = 0;
		for (int i = 0; i < `INES_HDR_LEN; i++)
			send_byte(hdr_byte(hdr, i));
		check_value({name, " busy after header"}, 32'd1, 32'(busy));
		for (int i = 0; i < prg_len + chr_len; i++) begin
			payload.push_back(8'($random(seed)));
			send_byte(payload[i]);
		end
		while (!done) @(posedge clk);
		while (ioctl_wait) @(posedge clk);  // Last byte committed
		check_value({name, " error"}, 32'(t_err[idx]), 32'(error));
		check_value({name, " busy at done"}, 32'd0, 32'(busy));
		check_value({name, " mapper_flags"}, t_flags[idx], mapper_flags);
		check_value({name, " write count"}, 32'(total), 32'(write_count));
		check_value({name, " chr region writes"}, 32'(chr_len), 32'(chr_writes));
		for (int i = 0; i < `INES_HDR_LEN; i++) begin
			check_value($sformatf("%s header addr %0d", name, i), 32'(i), 32'(hdr_log_addr[i]));
			check_value($sformatf("%s header byte %0d", name, i), 32'(hdr_byte(hdr, i)),
				32'(hdr_log_data[i]));
		end
		for (int i = 0; i < prg_len + chr_len; i++) begin
			a = (i < prg_len) ? addr_t'(i) : addr_t'(`CHR_BASE_ADDR + i - prg_len);
			if (!mem_model.exists(a))
				fail_run($sformatf("%s: no write reached address %h", name, a));
			check_value($sformatf("%s byte at %h", name, a), 32'(payload[i]), 32'(mem_model[a]));
		end
		for (int i = 0; i < TRAIL_BYTES; i++)
			send_byte(8'($random(seed)));
		repeat (2 * `MEM_SLOT_DIV) @(posedge clk);
		check_value({name, " writes after done"}, 32'(total), 32'(write_count));
		downloading <= 1'b0;
	endtask

	initial begin
		longint total_bytes;
		reset_nes        = 1'b1;
		downloading      = 1'b0;
		indata           = 8'h00;
		indata_clk       = 1'b0;
		invert_mirroring = 1'b0;
		load_tests();
		total_bytes = 0;
		foreach (t_name[i])
			total_bytes += `INES_HDR_LEN + TRAIL_BYTES +
				(t_err[i] ? 0 : prg_length(t_hdr[i]) + chr_length(t_hdr[i]));
		// Eight slots per byte is far above the real host pace
		watch_ns = total_bytes * 8 * `MEM_SLOT_DIV * CLK_PERIOD + t_name.size() * 1000 + 10_000;
		foreach (t_name[i])
			run_test(i);
		$display("Result: PASSED");
		$finish;
	end

endmodule

`default_nettype wire
